// File: regex_cpu.f
+incdir+hdl
hdl/regex_pkg.sv
hdl/regex_fetch.sv
hdl/regex_execute.sv
hdl/pc_fifo.sv
hdl/pc_arbiter.sv
hdl/regex_cpu.sv
verif/regex_cpu_chk.sv
verif/regex_cpu_tb.sv

// File: Bender.yml
package:
  name: regex_cpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/regex_pkg.sv
      - hdl/regex_fetch.sv
      - hdl/regex_execute.sv
      - hdl/pc_fifo.sv
      - hdl/pc_arbiter.sv
      - hdl/regex_cpu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/regex_cpu_chk.sv
      - verif/regex_cpu_tb.sv

// File: verif/regex_cpu_tb.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module regex_cpu_tb;
    localparam int MEM_WORDS = 1 << `REGEX_MEM_ADDR_WIDTH;
    localparam int NUM_ROWS = 11;

    typedef logic [`REGEX_PC_WIDTH-1:0] pc_t;
    typedef logic [`REGEX_FIFO_DEPTH_LOG2:0] latency_t;

    // one instruction run, expected continuations may arrive in either order
    typedef struct packed {
        logic [`REGEX_OPCODE_WIDTH-1:0] opcode;
        logic [`REGEX_CHAR_WIDTH-1:0]   operand;
        logic [`REGEX_CHAR_WIDTH-1:0]   character;
        pc_t                            pc;
        logic                           accept;
        logic [1:0]                     n_out;
        pc_t                            pc0;
        logic                           cur0;
        pc_t                            pc1;
        logic                           cur1;
    } row_t;

    logic                             clk = 1'b0;
    logic                             reset;
    logic [`REGEX_CHAR_WIDTH-1:0]     current_character;
    logic                             input_pc_valid;
    pc_t                              input_pc;
    logic                             input_pc_ready;
    logic                             memory_ready;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] memory_addr;
    logic [`REGEX_MEM_WIDTH-1:0]      memory_data;
    logic                             memory_valid;
    logic                             output_pc_is_directed_to_current;
    logic                             output_pc_valid;
    pc_t                              output_pc;
    logic                             output_pc_ready;
    logic                             accepts;
    logic                             running;
    latency_t                         latency;

    logic [`REGEX_MEM_WIDTH-1:0] mem [MEM_WORDS];
    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr = 16'd17;
    logic        hold_output;
    logic        accept_seen;
    pc_t         got_pc [$];
    logic        got_cur [$];
    pc_t         exp_pc [$];
    logic        exp_cur [$];

    regex_cpu u_regex_cpu (.*);

    bind regex_cpu regex_cpu_chk u_chk (.*);

    always #10 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic random_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [`REGEX_MEM_WIDTH-1:0] instr_word(
        input logic [`REGEX_OPCODE_WIDTH-1:0] opcode,
        input logic [`REGEX_CHAR_WIDTH-1:0]   operand
    );
        instr_word = '0;
        instr_word[`REGEX_INSTR_WIDTH-1:0] = {opcode, operand};
    endfunction

    // memory model, output sink and accept monitor
    always @(posedge clk)
    begin : sink_model
        logic                        fire;
        logic [`REGEX_MEM_WIDTH-1:0] word;
        logic                        next_mem_ready;
        logic                        next_out_ready;
        fire = memory_valid && memory_ready;
        word = fire ? mem[memory_addr] : '0;
        if (!reset && output_pc_valid && output_pc_ready)
        begin
            got_pc.push_back(output_pc);
            got_cur.push_back(output_pc_is_directed_to_current);
        end
        if (!reset && accepts)
            accept_seen = 1'b1;
        next_mem_ready = random_bit();
        next_out_ready = hold_output ? 1'b0 : random_bit();
        #2;
        memory_data = word;
        memory_ready = next_mem_ready;
        output_pc_ready = next_out_ready;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // stop at the first failing protocol assertion
    always @(posedge clk)
    begin
        if (u_regex_cpu.u_chk.failures != 0)
            fail_run("a protocol assertion in the bound checker failed");
    end

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: %s, pc %0h expected %0h",
                $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: %s, got %b expected %b",
                $time, what, got, exp));
    endtask

    task automatic check_latency(input latency_t got, input latency_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: %s, latency %0d expected %0d",
                $time, what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            fail_run($sformatf("CHECK FAILED at %0t: %s, got %0d expected %0d",
                $time, what, got, exp));
    endtask

    task automatic offer_thread(input pc_t pc, input int limit, output logic taken);
        int n;
        input_pc = pc;
        input_pc_valid = 1'b1;
        taken = 1'b0;
        for (n = 0; n < limit && !taken; n++)
        begin
            @(posedge clk);
            taken = input_pc_ready;
        end
        #2;
        input_pc_valid = 1'b0;
    endtask

    task automatic wait_idle(input int limit, input string tag);
        int n;
        for (n = 0; n < limit; n++)
        begin
            @(posedge clk);
            if (!running)
                break;
        end
        if (n == limit)
            fail_run({"timeout while waiting for running to fall in ", tag});
        #2;
    endtask

    // pair every expected continuation with a received one of the same pc
    task automatic compare_outputs(input string tag);
        int j;
        check_count(got_pc.size(), exp_pc.size(), {tag, " output count"});
        while (exp_pc.size() > 0)
        begin
            j = 0;
            for (int k = 0; k < got_pc.size(); k++)
                if (got_pc[k] == exp_pc[0])
                    j = k;
            check_pc(got_pc[j], exp_pc[0], {tag, " output pc"});
            check_flag(got_cur[j], exp_cur[0], {tag, " output direction"});
            got_pc.delete(j);
            got_cur.delete(j);
            exp_pc.delete(0);
            exp_cur.delete(0);
        end
    endtask

    task automatic run_row(input row_t row, input int index);
        string tag;
        logic  taken;
        tag = $sformatf("row %0d", index);
        mem[row.pc] = instr_word(row.opcode, row.operand);
        current_character = row.character;
        accept_seen = 1'b0;
        got_pc.delete();
        got_cur.delete();
        if (row.n_out != 2'd0)
        begin
            exp_pc.push_back(row.pc0);
            exp_cur.push_back(row.cur0);
        end
        if (row.n_out == 2'd2)
        begin
            exp_pc.push_back(row.pc1);
            exp_cur.push_back(row.cur1);
        end
        offer_thread(row.pc, 64, taken);
        if (!taken)
            fail_run({"timeout while waiting for input_pc_ready in ", tag});
        wait_idle(200, tag);
        check_flag(accept_seen, row.accept, {tag, " accepts"});
        compare_outputs(tag);
    endtask

    task automatic run_backpressure();
        int       accepted;
        int       n;
        logic     taken;
        latency_t seen;
        pc_t      pc;
        pc_t      target;
        accepted = 0;
        taken = 1'b1;
        seen = '0;
        hold_output = 1'b1;
        current_character = '0;
        got_pc.delete();
        got_cur.delete();
        for (int k = 0; k < 8 && taken; k++)
        begin
            pc = 8'h40 + 8'(2 * k);
            target = 8'h80 + 8'(k);
            mem[pc] = instr_word(`REGEX_OP_SPLIT, target);
            offer_thread(pc, 40, taken);
            if (taken)
            begin
                accepted++;
                exp_pc.push_back(pc + 8'd1);
                exp_cur.push_back(1'b1);
                exp_pc.push_back(target);
                exp_cur.push_back(1'b1);
            end
            if (taken && accepted == 3)
            begin
                for (n = 0; n < 40; n++)
                begin
                    @(posedge clk);
                    seen = latency;
                    if (seen == 3'd6)
                        break;
                end
                check_latency(seen, 3'd6, "three splits held in the buffers");
                #2;
            end
        end
        // four splits fill both buffers, one more waits in execute and one in fetch
        check_flag(taken, 1'b0, "input_pc_ready stays low under back-pressure");
        check_count(accepted, 6, "threads accepted before the stall");
        hold_output = 1'b0;
        wait_idle(400, "back-pressure release");
        compare_outputs("back-pressure release");
        check_latency(latency, '0, "latency after release");
    endtask

    task automatic load_rows();
        // opcode, operand, character, pc, accepts, outputs, two pc and direction pairs
        rows[0] = '{`REGEX_OP_ACCEPT, 8'h00, 8'h00, 8'h10,
                    1'b1, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
        rows[1] = '{`REGEX_OP_ACCEPT, 8'h00, 8'h61, 8'h11,
                    1'b0, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
        rows[2] = '{`REGEX_OP_ACCEPT_PARTIAL, 8'h00, 8'h62, 8'h12,
                    1'b1, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
        rows[3] = '{`REGEX_OP_END, 8'h00, 8'h00, 8'h13,
                    1'b0, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
        rows[4] = '{`REGEX_OP_MATCH, 8'h61, 8'h61, 8'h20,
                    1'b0, 2'd1, 8'h21, 1'b0, 8'h00, 1'b0};
        rows[5] = '{`REGEX_OP_MATCH, 8'h61, 8'h62, 8'h22,
                    1'b0, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
        rows[6] = '{`REGEX_OP_MATCH_ANY, 8'h00, 8'h7a, 8'h30,
                    1'b0, 2'd1, 8'h31, 1'b0, 8'h00, 1'b0};
        rows[7] = '{`REGEX_OP_JMP, 8'h90, 8'h00, 8'h40,
                    1'b0, 2'd1, 8'h90, 1'b1, 8'h00, 1'b0};
        rows[8] = '{`REGEX_OP_SPLIT, 8'ha0, 8'h00, 8'h50,
                    1'b0, 2'd2, 8'h51, 1'b1, 8'ha0, 1'b1};
        // pc+1 wraps at the top of the program
        rows[9] = '{`REGEX_OP_SPLIT, 8'h05, 8'h00, 8'hff,
                    1'b0, 2'd2, 8'h00, 1'b1, 8'h05, 1'b1};
        // unused opcode retires like end
        rows[10] = '{3'd7, 8'h00, 8'h00, 8'h60,
                     1'b0, 2'd0, 8'h00, 1'b0, 8'h00, 1'b0};
    endtask

    initial
    begin : main
        reset = 1'b1;
        current_character = '0;
        input_pc_valid = 1'b0;
        input_pc = '0;
        memory_ready = 1'b0;
        memory_data = '0;
        output_pc_ready = 1'b0;
        hold_output = 1'b0;
        accept_seen = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = 16'hf800 ^ 16'(a);
        load_rows();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(rows[r], r);
        run_backpressure();
        if (u_regex_cpu.u_chk.failures == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("RESULT: FAIL");
            $fatal(1, "protocol assertions failed during the run");
        end
    end

endmodule

// File: verif/regex_cpu_chk.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module regex_cpu_chk (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 input_pc_ready,
    input logic                                 running,
    input logic                                 output_pc_valid,
    input logic [`REGEX_PC_WIDTH-1:0]           output_pc,
    input logic                                 output_pc_is_directed_to_current,
    input logic                                 output_pc_ready,
    input logic [1:0][`REGEX_FIFO_DEPTH_LOG2:0] buf_count
);
    int failures = 0;

    // an offered continuation holds until the sink takes it
    a_output_stable: assert property (@(posedge clk) disable iff (reset)
        output_pc_valid && !output_pc_ready |=> output_pc_valid && $stable(output_pc)
            && $stable(output_pc_is_directed_to_current))
    else
    begin
        $error("output continuation changed before it was taken");
        failures++;
    end

    // an accepted thread is in flight on the next cycle
    a_input_starts_thread: assert property (@(posedge clk) disable iff (reset)
        input_pc_ready |=> running)
    else
    begin
        $error("input_pc_ready without a thread in flight afterwards");
        failures++;
    end

    // both buffers together never hold more than their total depth
    a_latency_bound: assert property (@(posedge clk) disable iff (reset)
        (5'(buf_count[0]) + 5'(buf_count[1])) <= 5'(2 << `REGEX_FIFO_DEPTH_LOG2))
    else
    begin
        $error("latency above the total buffer depth");
        failures++;
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |=> !output_pc_valid)
    else
    begin
        $error("output valid while in reset");
        failures++;
    end

endmodule

// File: hdl/regex_cpu.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module regex_cpu
    import regex_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [`REGEX_CHAR_WIDTH-1:0]      current_character,
    input  logic                              input_pc_valid,
    input  logic [`REGEX_PC_WIDTH-1:0]        input_pc,
    output logic                              input_pc_ready,
    input  logic                              memory_ready,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0]  memory_addr,
    input  logic [`REGEX_MEM_WIDTH-1:0]       memory_data,
    output logic                              memory_valid,
    output logic                              output_pc_is_directed_to_current,
    output logic                              output_pc_valid,
    output logic [`REGEX_PC_WIDTH-1:0]        output_pc,
    input  logic                              output_pc_ready,
    output logic                              accepts,
    output logic                              running,
    output logic [`REGEX_FIFO_DEPTH_LOG2:0]   latency
);
    logic                                   fetch_valid;
    logic [`REGEX_PC_WIDTH-1:0]             fetch_pc;
    logic [`REGEX_OPCODE_WIDTH-1:0]         fetch_opcode;
    regex_operand_u                         fetch_operand;
    logic                                   exe_ready;
    logic                                   exe_busy;
    logic [1:0]                             push_valid;
    logic [1:0][`REGEX_PC_WIDTH-1:0]        push_pc;
    logic [1:0]                             push_current;
    logic [1:0]                             push_ready;
    logic [1:0]                             buf_valid;
    logic [1:0][`REGEX_PC_WIDTH-1:0]        buf_pc;
    logic [1:0]                             buf_current;
    logic [1:0]                             buf_pop;
    logic [1:0][`REGEX_FIFO_DEPTH_LOG2:0]   buf_count;

    regex_fetch u_fetch (
        .clk            (clk),
        .reset          (reset),
        .input_pc_valid (input_pc_valid),
        .input_pc       (input_pc),
        .input_pc_ready (input_pc_ready),
        .memory_ready   (memory_ready),
        .memory_data    (memory_data),
        .memory_valid   (memory_valid),
        .memory_addr    (memory_addr),
        .exe_ready      (exe_ready),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_opcode   (fetch_opcode),
        .fetch_operand  (fetch_operand)
    );

    regex_execute u_execute (
        .clk               (clk),
        .reset             (reset),
        .current_character (current_character),
        .fetch_valid       (fetch_valid),
        .fetch_pc          (fetch_pc),
        .fetch_opcode      (fetch_opcode),
        .fetch_operand     (fetch_operand),
        .exe_ready         (exe_ready),
        .push_valid        (push_valid),
        .push_pc           (push_pc),
        .push_current      (push_current),
        .push_ready        (push_ready),
        .accepts           (accepts),
        .busy              (exe_busy)
    );

    // one continuation buffer per execute stage
    for (genvar i = 0; i < 2; i++)
    begin : g_buffer
        pc_fifo #(
            .DEPTH_LOG2 (`REGEX_FIFO_DEPTH_LOG2)
        ) u_pc_fifo (
            .clk          (clk),
            .reset        (reset),
            .push_valid   (push_valid[i]),
            .push_pc      (push_pc[i]),
            .push_current (push_current[i]),
            .push_ready   (push_ready[i]),
            .pop_valid    (buf_valid[i]),
            .pop_pc       (buf_pc[i]),
            .pop_current  (buf_current[i]),
            .pop_ready    (buf_pop[i]),
            .count        (buf_count[i])
        );
    end

    pc_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (buf_valid),
        .in_pc       (buf_pc),
        .in_current  (buf_current),
        .in_ready    (buf_pop),
        .out_valid   (output_pc_valid),
        .out_pc      (output_pc),
        .out_current (output_pc_is_directed_to_current),
        .out_ready   (output_pc_ready)
    );

    // status
    assign running = fetch_valid || exe_busy || (buf_valid != 2'b00);
    assign latency = buf_count[0] + buf_count[1];

endmodule

// File: hdl/pc_arbiter.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module pc_arbiter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [1:0]                       in_valid,
    input  logic [1:0][`REGEX_PC_WIDTH-1:0]  in_pc,
    input  logic [1:0]                       in_current,
    output logic [1:0]                       in_ready,
    output logic                             out_valid,
    output logic [`REGEX_PC_WIDTH-1:0]       out_pc,
    output logic                             out_current,
    input  logic                             out_ready
);
    logic last;
    logic hold;
    logic hold_sel;
    logic pick;
    logic sel;

    // with both pending the one not served last goes first
    assign pick = (in_valid[0] && in_valid[1]) ? !last : in_valid[1];
    assign sel = hold ? hold_sel : pick;

    assign out_valid = in_valid[sel];
    assign out_pc = in_pc[sel];
    assign out_current = in_current[sel];
    assign in_ready[0] = out_ready && !sel;
    assign in_ready[1] = out_ready && sel;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last <= 1'b1;
            hold <= 1'b0;
            hold_sel <= 1'b0;
        end
        else
        begin
            // keep the offered entry until it is taken
            hold <= out_valid && !out_ready;
            hold_sel <= sel;
            if (out_valid && out_ready)
                last <= sel;
            else if (in_valid == 2'b00)
                last <= 1'b1; // idle, input 0 wins next
        end
    end

endmodule

// File: hdl/pc_fifo.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module pc_fifo #(
    parameter int DEPTH_LOG2 = 2
)(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push_valid,
    input  logic [`REGEX_PC_WIDTH-1:0]  push_pc,
    input  logic                        push_current,
    output logic                        push_ready,
    output logic                        pop_valid,
    output logic [`REGEX_PC_WIDTH-1:0]  pop_pc,
    output logic                        pop_current,
    input  logic                        pop_ready,
    output logic [DEPTH_LOG2:0]         count
);
    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [`REGEX_PC_WIDTH-1:0] mem_pc [DEPTH];
    logic                       mem_current [DEPTH];
    logic [DEPTH_LOG2-1:0]      wr_ptr;
    logic [DEPTH_LOG2-1:0]      rd_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign push_ready = (count != DEPTH[DEPTH_LOG2:0]);
    assign pop_valid = (count != '0);
    assign pop_pc = mem_pc[rd_ptr];
    assign pop_current = mem_current[rd_ptr];
    assign do_push = push_valid && push_ready;
    assign do_pop = pop_valid && pop_ready;

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem_pc[wr_ptr] <= push_pc;
            mem_current[wr_ptr] <= push_current;
        end
    end

endmodule

// File: hdl/regex_execute.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module regex_execute
    import regex_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic [`REGEX_CHAR_WIDTH-1:0]        current_character,
    input  logic                                fetch_valid,
    input  logic [`REGEX_PC_WIDTH-1:0]          fetch_pc,
    input  logic [`REGEX_OPCODE_WIDTH-1:0]      fetch_opcode,
    input  regex_operand_u                      fetch_operand,
    output logic                                exe_ready,
    output logic [1:0]                          push_valid,
    output logic [1:0][`REGEX_PC_WIDTH-1:0]     push_pc,
    output logic [1:0]                          push_current,
    input  logic [1:0]                          push_ready,
    output logic                                accepts,
    output logic                                busy
);
    logic                           s1_valid;
    logic [`REGEX_PC_WIDTH-1:0]     s1_pc;
    logic [`REGEX_OPCODE_WIDTH-1:0] s1_opcode;
    regex_operand_u                 s1_operand;
    logic                           s2_valid;
    logic [`REGEX_PC_WIDTH-1:0]     s2_target;
    logic                           s1_push;
    logic                           s1_to_s2;
    logic                           s1_accepts;
    logic                           s2_free;
    logic                           s2_ok;
    logic                           s1_advance;
    logic                           s2_advance;

    // stage 1 decode
    always_comb
    begin
        s1_push = 1'b0;
        s1_to_s2 = 1'b0;
        s1_accepts = 1'b0;
        push_pc[0] = s1_pc + 1'b1;
        push_current[0] = 1'b1;
        if (s1_valid)
        begin
            case (s1_opcode)
                `REGEX_OP_ACCEPT:
                    s1_accepts = (current_character == '0);
                `REGEX_OP_ACCEPT_PARTIAL:
                    s1_accepts = 1'b1;
                `REGEX_OP_SPLIT:
                begin
                    s1_push = 1'b1;
                    s1_to_s2 = 1'b1;
                end
                `REGEX_OP_MATCH:
                begin
                    s1_push = (current_character == s1_operand.character);
                    push_current[0] = 1'b0;
                end
                `REGEX_OP_MATCH_ANY:
                begin
                    s1_push = 1'b1;
                    push_current[0] = 1'b0;
                end
                `REGEX_OP_JMP:
                begin
                    s1_push = 1'b1;
                    push_pc[0] = s1_operand.target;
                end
                default:
                    s1_push = 1'b0; // end and unknown codes just retire
            endcase
        end
    end

    // stage 2 only ever holds the second half of a split
    assign push_valid[1] = s2_valid;
    assign push_pc[1] = s2_target;
    assign push_current[1] = 1'b1;

    // stall chain
    assign s2_advance = s2_valid && push_ready[1];
    assign s2_free = !s2_valid || s2_advance;
    assign s2_ok = !s1_to_s2 || s2_free;
    assign push_valid[0] = s1_push && s2_ok;
    assign s1_advance = s1_valid && s2_ok && (!s1_push || push_ready[0]);
    assign exe_ready = !s1_valid || s1_advance;

    assign accepts = s1_accepts;
    assign busy = s1_valid || s2_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (s1_advance && s1_to_s2)
                s2_valid <= 1'b1;
            else if (s2_advance)
                s2_valid <= 1'b0;
            if (exe_ready)
                s1_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exe_ready)
        begin
            s1_pc <= fetch_pc;
            s1_opcode <= fetch_opcode;
            s1_operand <= fetch_operand;
        end
        if (s1_advance && s1_to_s2)
            s2_target <= s1_operand.target;
    end

endmodule

// File: hdl/regex_fetch.sv
`timescale 1ns/1ns
`include "regex_macros.svh"

module regex_fetch
    import regex_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             input_pc_valid,
    input  logic [`REGEX_PC_WIDTH-1:0]       input_pc,
    output logic                             input_pc_ready,
    input  logic                             memory_ready,
    input  logic [`REGEX_MEM_WIDTH-1:0]      memory_data,
    output logic                             memory_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic                             exe_ready,
    output logic                             fetch_valid,
    output logic [`REGEX_PC_WIDTH-1:0]       fetch_pc,
    output logic [`REGEX_OPCODE_WIDTH-1:0]   fetch_opcode,
    output regex_operand_u                   fetch_operand
);
    logic                           rec_valid;
    logic                           rec_has_to_save;
    logic [`REGEX_PC_WIDTH-1:0]     rec_pc;
    logic [`REGEX_OPCODE_WIDTH-1:0] rec_opcode;
    regex_operand_u                 rec_operand;
    logic [`REGEX_INSTR_WIDTH-1:0]  mem_instr;
    logic                           rec_advance;
    logic                           send_ok;
    logic                           send_fire;

    // send stage, only requests when the receive slot can take the word
    assign rec_advance = rec_valid && exe_ready;
    assign send_ok = input_pc_valid && (!rec_valid || rec_advance);
    assign send_fire = send_ok && memory_ready;
    assign memory_valid = send_ok;
    assign input_pc_ready = send_fire;
    assign memory_addr = {{(`REGEX_MEM_ADDR_WIDTH - `REGEX_PC_WIDTH){1'b0}}, input_pc};

    // receive stage, memory word is only present right after the handshake
    assign mem_instr = memory_data[`REGEX_INSTR_WIDTH-1:0];
    assign fetch_valid = rec_valid;
    assign fetch_pc = rec_pc;
    assign fetch_opcode = rec_has_to_save
        ? mem_instr[`REGEX_INSTR_WIDTH-1 -: `REGEX_OPCODE_WIDTH] : rec_opcode;
    assign fetch_operand = rec_has_to_save
        ? mem_instr[`REGEX_CHAR_WIDTH-1:0] : rec_operand;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rec_valid <= 1'b0;
            rec_has_to_save <= 1'b0;
        end
        else
        begin
            rec_has_to_save <= send_fire;
            if (send_fire)
                rec_valid <= 1'b1;
            else if (rec_advance)
                rec_valid <= 1'b0;
        end
    end

    // slot keeps the captured instruction while execute stalls
    always_ff @(posedge clk)
    begin
        if (send_fire)
            rec_pc <= input_pc;
        rec_opcode <= fetch_opcode;
        rec_operand <= fetch_operand;
    end

endmodule

// File: hdl/regex_pkg.sv
`include "regex_macros.svh"

package regex_pkg;

    // operand field of an instruction
    // match reads it as a literal, jump and split as a target pc
    typedef union packed
    {
        logic [`REGEX_CHAR_WIDTH-1:0] character;
        logic [`REGEX_PC_WIDTH-1:0]   target;
    } regex_operand_u;

endpackage

// File: hdl/regex_macros.svh
`ifndef REGEX_MACROS_SVH
`define REGEX_MACROS_SVH

// datapath widths
`define REGEX_PC_WIDTH        8
`define REGEX_CHAR_WIDTH      8
`define REGEX_MEM_WIDTH       16
`define REGEX_MEM_ADDR_WIDTH  11

// instruction layout, opcode on top of an 8-bit operand
`define REGEX_OPCODE_WIDTH    3
`define REGEX_INSTR_WIDTH     11

// opcode encodings
`define REGEX_OP_ACCEPT          3'd0
`define REGEX_OP_ACCEPT_PARTIAL  3'd1
`define REGEX_OP_SPLIT           3'd2
`define REGEX_OP_MATCH           3'd3
`define REGEX_OP_MATCH_ANY       3'd4
`define REGEX_OP_JMP             3'd5
`define REGEX_OP_END             3'd6

// continuation buffers hold 2**N entries
`define REGEX_FIFO_DEPTH_LOG2 2

`endif
